/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := cache_tb
RTL_TOP    := cache_top
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
common/cache_pkg.sv
common/cache_lookup_if.sv
cache/cache_req_stage.sv
cache/cache_store.sv
cache/cache_mem_ctrl.sv
hdl/cache_top.sv
tb/cache_chk.sv
tb/cache_tb.sv

/* cache/cache_mem_ctrl.sv */
// cache miss controller
`timescale 1ns/1ps

module cache_mem_ctrl #(
	parameter int INDEX_W = cache_pkg::DEFAULT_INDEX_W
) (
	input  logic                              clk,
	input  logic                              rst_n,
	cache_lookup_if.ctrl                      lookup,
	input  logic                              hit,
	input  logic                              victim_valid,
	input  logic [cache_pkg::ADDR_W-INDEX_W-cache_pkg::OFFSET_W-1:0] victim_tag,
	input  cache_pkg::line_t                  victim_line,
	output logic                              fill_en,
	output cache_pkg::line_t                  fill_line,
	output logic                              done,
	output logic                              mem_req_valid,
	output logic                              mem_write,
	output logic [cache_pkg::MEM_ADDR_W-1:0]  mem_addr,
	output cache_pkg::line_t                  mem_wdata,
	input  logic                              mem_req_ready,
	input  logic                              mem_rdata_valid,
	input  cache_pkg::line_t                  mem_rdata
);

	cache_pkg::ctrl_state_t state_q;
	cache_pkg::ctrl_state_t state_d;

	// ------------------------------
	// state register
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= cache_pkg::idle;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::idle: begin
				if (lookup.valid && !hit) begin
					// valid victim always goes out, no dirty bit
					if (victim_valid)
						state_d = cache_pkg::write_back;
					else
						state_d = cache_pkg::refill_req;
				end
			end
			cache_pkg::write_back: begin
				if (mem_req_ready)
					state_d = cache_pkg::refill_req;
			end
			cache_pkg::refill_req: begin
				if (mem_req_ready)
					state_d = cache_pkg::refill_wait;
			end
			cache_pkg::refill_wait: begin
				if (mem_rdata_valid)
					state_d = cache_pkg::idle;
			end
			default: state_d = cache_pkg::idle;
		endcase
	end

	// ------------------------------
	// outputs
	// ------------------------------

	// served once the line is present
	assign done = (state_q == cache_pkg::idle) && hit;

	assign fill_en   = (state_q == cache_pkg::refill_wait) && mem_rdata_valid;
	assign fill_line = mem_rdata;

	assign mem_req_valid = (state_q == cache_pkg::write_back) ||
	                       (state_q == cache_pkg::refill_req);
	assign mem_write     = (state_q == cache_pkg::write_back);

	// victim address while writing back, else the requested line
	always_comb begin
		if (state_q == cache_pkg::write_back)
			mem_addr = {victim_tag, lookup.index};
		else
			mem_addr = {lookup.tag, lookup.index};
	end

	// array is not written during write-back, so the line holds
	assign mem_wdata = victim_line;

endmodule

/* cache/cache_req_stage.sv */
// cache request stage
`timescale 1ns/1ps

module cache_req_stage #(
	parameter int INDEX_W = cache_pkg::DEFAULT_INDEX_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req_valid,
	input  logic                          req_write,
	input  logic [cache_pkg::ADDR_W-1:0]  req_addr,
	input  logic [cache_pkg::WORD_W-1:0]  req_wdata,
	output logic                          req_ready,
	output logic                          resp_valid,
	output logic [cache_pkg::WORD_W-1:0]  resp_rdata,
	input  logic                          resp_ready,
	cache_lookup_if.source                lookup,
	input  logic [cache_pkg::WORD_W-1:0]  rdata,
	input  logic                          done
);

	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;

	logic                            busy_q;    // request held on the bus
	logic                            write_q;
	logic [INDEX_W-1:0]              index_q;
	logic [TAG_W-1:0]                tag_q;
	logic [cache_pkg::OFFSET_W-1:0]  word_q;
	logic [cache_pkg::WORD_W-1:0]    wdata_q;
	logic                            accept;

	// one request in flight, response must drain first
	assign req_ready = !busy_q && !resp_valid;
	assign accept    = req_valid && req_ready;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q     <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			if (accept)
				busy_q <= 1'b1;
			else if (done)
				busy_q <= 1'b0;

			if (done)
				resp_valid <= 1'b1;
			else if (resp_ready)
				resp_valid <= 1'b0;   // transfer taken
		end
	end

	// address split: tag | index | word
	always_ff @(posedge clk) begin
		if (accept) begin
			write_q <= req_write;
			tag_q   <= req_addr[cache_pkg::ADDR_W-1 -: TAG_W];
			index_q <= req_addr[cache_pkg::OFFSET_W +: INDEX_W];
			word_q  <= req_addr[cache_pkg::OFFSET_W-1:0];
			wdata_q <= req_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (done)
			resp_rdata <= rdata;
	end

	assign lookup.valid = busy_q;
	assign lookup.write = write_q;
	assign lookup.index = index_q;
	assign lookup.tag   = tag_q;
	assign lookup.word  = word_q;
	assign lookup.wdata = wdata_q;

endmodule

/* cache/cache_store.sv */
// cache line store
`timescale 1ns/1ps

module cache_store #(
	parameter int INDEX_W = cache_pkg::DEFAULT_INDEX_W
) (
	input  logic                           clk,
	input  logic                           rst_n,
	cache_lookup_if.store                  lookup,
	output logic                           hit,
	output logic                           victim_valid,
	output logic [cache_pkg::ADDR_W-INDEX_W-cache_pkg::OFFSET_W-1:0] victim_tag,
	output cache_pkg::line_t               victim_line,
	output logic [cache_pkg::WORD_W-1:0]   rdata,
	input  logic                           fill_en,
	input  cache_pkg::line_t               fill_line
);

	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;
	localparam int LINES = 2 ** INDEX_W;

	// ------------------------------
	// arrays
	// ------------------------------
	logic [LINES-1:0]    valid_q;
	logic [TAG_W-1:0]    tag_q  [LINES];
	cache_pkg::line_t    data_q [LINES];

	logic                word_we;

	// indexed line, also the victim on a miss
	assign victim_valid = valid_q[lookup.index];
	assign victim_tag   = tag_q[lookup.index];
	assign victim_line  = data_q[lookup.index];

	// full tag compare
	assign hit = lookup.valid && victim_valid && (victim_tag == lookup.tag);

	assign word_we = hit && lookup.write;

	// a write returns the value it stores
	assign rdata = lookup.write ? lookup.wdata : victim_line[lookup.word];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;   // all lines empty
		end else if (fill_en) begin
			valid_q[lookup.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_q[lookup.index]  <= lookup.tag;
			data_q[lookup.index] <= fill_line;
		end else if (word_we) begin
			data_q[lookup.index][lookup.word] <= lookup.wdata;
		end
	end

endmodule

/* common/cache_lookup_if.sv */
// cache lookup bus
`timescale 1ns/1ps

interface cache_lookup_if #(
	parameter int INDEX_W = cache_pkg::DEFAULT_INDEX_W
);

	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;

	// held client request
	logic                            valid;
	logic                            write;
	logic [INDEX_W-1:0]              index;
	logic [TAG_W-1:0]                tag;
	logic [cache_pkg::OFFSET_W-1:0]  word;    // word within line
	logic [cache_pkg::WORD_W-1:0]    wdata;

	// request stage side
	modport source (
		output valid,
		output write,
		output index,
		output tag,
		output word,
		output wdata
	);

	// arrays need the whole request
	modport store (
		input valid,
		input write,
		input index,
		input tag,
		input word,
		input wdata
	);

	// controller only builds line addresses
	modport ctrl (
		input valid,
		input index,
		input tag
	);

endinterface

/* common/cache_pkg.sv */
// cache shared definitions
package cache_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int ADDR_W = 30;              // client word address
	localparam int WORD_W = 32;
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_W = 2;             // word within line
	localparam int LINE_W = LINE_WORDS * WORD_W;
	localparam int MEM_ADDR_W = ADDR_W - OFFSET_W;   // memory line address

	localparam int DEFAULT_INDEX_W = 3;      // 8 lines

	// ------------------------------
	// types
	// ------------------------------

	// word 0 sits in the low bits
	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

	// miss handling states
	typedef enum logic [1:0] {
		idle,
		write_back,   // victim line out to memory
		refill_req,   // read request for the missing line
		refill_wait   // waiting on read data
	} ctrl_state_t;

endpackage

/* hdl/cache_top.sv */
// direct-mapped cache top
`timescale 1ns/1ps

module cache_top #(
	parameter int INDEX_W = cache_pkg::DEFAULT_INDEX_W
) (
	input  logic                              clk,
	input  logic                              rst_n,
	// client request
	input  logic                              req_valid,
	output logic                              req_ready,
	input  logic                              req_write,
	input  logic [cache_pkg::ADDR_W-1:0]      req_addr,
	input  logic [cache_pkg::WORD_W-1:0]      req_wdata,
	// client response
	output logic                              resp_valid,
	input  logic                              resp_ready,
	output logic [cache_pkg::WORD_W-1:0]      resp_rdata,
	// memory
	output logic                              mem_req_valid,
	input  logic                              mem_req_ready,
	output logic                              mem_write,
	output logic [cache_pkg::MEM_ADDR_W-1:0]  mem_addr,
	output logic [cache_pkg::LINE_W-1:0]      mem_wdata,
	input  logic                              mem_rdata_valid,
	input  logic [cache_pkg::LINE_W-1:0]      mem_rdata
);

	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;

	// ------------------------------
	// internal wiring
	// ------------------------------
	logic                          hit;
	logic                          victim_valid;
	logic [TAG_W-1:0]              victim_tag;
	cache_pkg::line_t              victim_line;
	logic [cache_pkg::WORD_W-1:0]  rdata;
	logic                          fill_en;
	cache_pkg::line_t              fill_line;
	logic                          done;

	cache_lookup_if #(.INDEX_W(INDEX_W)) lookup ();

	cache_req_stage #(.INDEX_W(INDEX_W)) req_stage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_write  (req_write),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_rdata (resp_rdata),
		.resp_ready (resp_ready),
		.lookup     (lookup.source),
		.rdata      (rdata),
		.done       (done)
	);

	cache_store #(.INDEX_W(INDEX_W)) store_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.lookup       (lookup.store),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.rdata        (rdata),
		.fill_en      (fill_en),
		.fill_line    (fill_line)
	);

	cache_mem_ctrl #(.INDEX_W(INDEX_W)) mem_ctrl_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.lookup          (lookup.ctrl),
		.hit             (hit),
		.victim_valid    (victim_valid),
		.victim_tag      (victim_tag),
		.victim_line     (victim_line),
		.fill_en         (fill_en),
		.fill_line       (fill_line),
		.done            (done),
		.mem_req_valid   (mem_req_valid),
		.mem_write       (mem_write),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_req_ready   (mem_req_ready),
		.mem_rdata_valid (mem_rdata_valid),
		.mem_rdata       (mem_rdata)
	);

endmodule

/* tb/cache_chk.sv */
// cache handshake checker
`timescale 1ns/1ps

module cache_chk (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              req_ready,
	input logic                              resp_valid,
	input logic                              resp_ready,
	input logic [cache_pkg::WORD_W-1:0]      resp_rdata,
	input logic                              mem_req_valid,
	input logic                              mem_req_ready,
	input logic                              mem_write,
	input logic [cache_pkg::MEM_ADDR_W-1:0]  mem_addr,
	input logic [cache_pkg::LINE_W-1:0]      mem_wdata
);

	int unsigned fail_count = 0;   // failed assertions so far

	// memory request and payload held until taken
	mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_write) &&
		$stable(mem_addr) && $stable(mem_wdata))
		else begin
			fail_count++;
			$error("memory request dropped or changed before mem_req_ready");
		end

	// response held under back-pressure
	resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
		else begin
			fail_count++;
			$error("response dropped or changed before resp_ready");
		end

	// nothing pending while a new request may be taken
	ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
		req_ready |-> !resp_valid && !mem_req_valid)
		else begin
			fail_count++;
			$error("req_ready high while a response or memory request is pending");
		end

endmodule

bind cache_top cache_chk chk_i (.*);

/* tb/cache_tb.sv */
// cache testbench
`timescale 1ns/1ps

module cache_tb;

	localparam int INDEX_W    = cache_pkg::DEFAULT_INDEX_W;
	localparam int MAX_CYCLES = 20000;   // about 4x the worst-case test length
	localparam int HIT_EDGES  = 2;       // done then resp_valid

	typedef logic [cache_pkg::ADDR_W-1:0]     addr_t;
	typedef logic [cache_pkg::WORD_W-1:0]     word_t;
	typedef logic [cache_pkg::MEM_ADDR_W-1:0] line_addr_t;

	logic clk = 1'b0;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	logic req_write;
	addr_t req_addr;
	word_t req_wdata;
	logic resp_valid;
	logic resp_ready;
	word_t resp_rdata;
	logic mem_req_valid;
	logic mem_req_ready = 1'b0;
	logic mem_write;
	line_addr_t mem_addr;
	logic [cache_pkg::LINE_W-1:0] mem_wdata;
	logic mem_rdata_valid = 1'b0;
	logic [cache_pkg::LINE_W-1:0] mem_rdata = '0;

	int unsigned cycles;
	int unsigned ready_wait;   // cycles until the memory takes a request
	int unsigned rd_wait;      // refill data countdown
	int unsigned wb_count;
	int unsigned rd_count;
	int unsigned wb_word;
	logic bp_on;               // random resp_ready
	line_addr_t rd_addr;
	line_addr_t last_wb_addr;
	cache_pkg::line_t wb_line;
	cache_pkg::line_t mem_lines [line_addr_t];   // lines written back
	word_t ref_words [addr_t];                   // client writes

	cache_top #(.INDEX_W(INDEX_W)) cache_top_i (.*);

	always #2 clk = ~clk;

	// memory rule is the word address XOR 5a5a_0000
	function automatic word_t rule_word(input addr_t addr);
		return word_t'(addr) ^ 32'h5a5a_0000;
	endfunction

	function automatic word_t expected_word(input addr_t addr);
		if (ref_words.exists(addr))
			return ref_words[addr];
		return rule_word(addr);
	endfunction

	function automatic cache_pkg::line_t read_line(input line_addr_t line_addr);
		cache_pkg::line_t line;
		if (mem_lines.exists(line_addr))
			return mem_lines[line_addr];
		for (int w = 0; w < cache_pkg::LINE_WORDS; w++)
			line[w] = rule_word({line_addr, 2'(w)});
		return line;
	endfunction

	function automatic addr_t make_addr(input int unsigned tag, input int unsigned index,
	                                    input int unsigned word);
		return addr_t'((tag << (INDEX_W + cache_pkg::OFFSET_W)) |
		               (index << cache_pkg::OFFSET_W) | word);
	endfunction

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
			$display("Result: FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	always @(posedge clk) begin
		if (cache_top_i.chk_i.fail_count != 0) begin
			$display("Error at time %0t: a handshake assertion in the checker failed", $time);
			$display("Result: FAILED");
			$fatal(1, "assertion failure");
		end
	end

	// ------------------------------
	// memory model
	// ------------------------------
	always begin
		@(posedge clk);
		if (rst_n) begin
			if (rd_wait > 0)
				rd_wait--;
			if (mem_req_valid && mem_req_ready) begin
				if (mem_write) begin
					wb_count++;
					last_wb_addr = mem_addr;
					wb_line = mem_wdata;
					for (wb_word = 0; wb_word < cache_pkg::LINE_WORDS; wb_word++)
						check($sformatf("mem_wdata word %0d", wb_word), wb_line[wb_word],
						      expected_word({mem_addr, 2'(wb_word)}));
					mem_lines[mem_addr] = mem_wdata;
				end else begin
					rd_count++;
					rd_addr = mem_addr;
					rd_wait = $urandom_range(5, 2);
				end
				ready_wait = $urandom_range(3, 0);
			end else if (mem_req_valid && ready_wait > 0) begin
				ready_wait--;
			end
		end
		#1;
		mem_req_ready   = (ready_wait == 0);
		mem_rdata_valid = (rd_wait == 1);
		mem_rdata       = (rd_wait == 1) ? read_line(rd_addr) : '0;
	end

	// one client access with its response checked against the reference model
	task automatic access(input logic write, input addr_t addr, input word_t wdata,
	                      output int unsigned edges);
		word_t exp;
		logic taken;
		exp = write ? wdata : expected_word(addr);
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		req_wdata = wdata;
		do
			@(posedge clk);
		while (!req_ready);
		edges = 0;
		#1;
		req_valid  = 1'b0;
		resp_ready = !bp_on || ($urandom_range(3, 0) != 0);
		do begin
			@(posedge clk);
			edges++;
			taken = resp_valid && resp_ready;
			if (!taken) begin
				#1;
				resp_ready = !bp_on || ($urandom_range(3, 0) != 0);
			end
		end while (!taken);
		check("resp_rdata", resp_rdata, exp);
		if (write)
			ref_words[addr] = wdata;
		#1;
		resp_ready = 1'b1;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_state_test();
		int unsigned edges;
		int unsigned wb0;
		int unsigned rd0;
		wb0 = wb_count;
		rd0 = rd_count;
		check("req_ready", 32'(req_ready), 32'd1);
		check("resp_valid", 32'(resp_valid), 32'd0);
		check("mem_req_valid", 32'(mem_req_valid), 32'd0);
		check("mem_write", 32'(mem_write), 32'd0);
		access(1'b0, make_addr(1, 0, 0), '0, edges);
		check("write-back count", wb_count - wb0, 32'd0);   // empty line so nothing to evict
		check("refill count", rd_count - rd0, 32'd1);
	endtask

	task automatic read_miss_test();
		int unsigned edges;
		int unsigned rd0;
		rd0 = rd_count;
		access(1'b0, make_addr(2, 1, 1), '0, edges);
		check("refill count", rd_count - rd0, 32'd1);
		rd0 = rd_count;
		access(1'b0, make_addr(2, 1, 3), '0, edges);
		check("hit latency", edges, HIT_EDGES);
		check("refill count", rd_count - rd0, 32'd0);
	endtask

	task automatic write_hit_test();
		int unsigned edges;
		int unsigned rd0;
		rd0 = rd_count;
		access(1'b1, make_addr(2, 1, 2), 32'hcafe_0123, edges);
		check("hit latency", edges, HIT_EDGES);
		access(1'b0, make_addr(2, 1, 2), '0, edges);
		check("refill count", rd_count - rd0, 32'd0);
	endtask

	task automatic eviction_test();
		int unsigned edges;
		int unsigned wb0;
		int unsigned rd0;
		wb0 = wb_count;
		rd0 = rd_count;
		access(1'b0, make_addr(5, 1, 0), '0, edges);
		check("write-back count", wb_count - wb0, 32'd1);
		check("refill count", rd_count - rd0, 32'd1);
		check("mem_addr", 32'(last_wb_addr), 32'(make_addr(2, 1, 0) >> cache_pkg::OFFSET_W));
		// written word comes back from memory
		access(1'b0, make_addr(2, 1, 2), '0, edges);
	endtask

	task automatic random_mix_test();
		int unsigned edges;
		addr_t addr;
		bp_on = 1'b1;
		for (int i = 0; i < 300; i++) begin
			addr = make_addr($urandom_range(3, 0), $urandom_range(1, 0), $urandom_range(3, 0));
			access($urandom_range(1, 0) == 1, addr, $urandom(), edges);
		end
		bp_on = 1'b0;
	endtask

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(32'ha5ef_4cd4));
		bp_on       = 1'b0;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req_write   = 1'b0;
		req_addr    = '0;
		req_wdata   = '0;
		resp_ready  = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_state_test();
		read_miss_test();
		write_hit_test();
		eviction_test();
		random_mix_test();
		if (cache_top_i.chk_i.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
